// File: Makefile
# Verilator build and run of the register file testbench
# any variable below can be set on the command line, e.g. make test TOP=...

VERILATOR ?= verilator
TOP       ?= regFileTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

# a failing run ends in \$$fatal, which gives a nonzero exit status
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: build.f
+incdir+verilog
verilog/regFilePkg.sv
verilog/rfWriteStage.sv
verilog/rfStorageArray.sv
verilog/rfReadStage.sv
verilog/rfObserveFlops.sv
verilog/regFileTop.sv
tests/regFileTb.sv

// File: tests/regFileTb.sv
//----------------------------------------------------------------------
// testbench of the register file with the clock, the reset, seeded
// random traffic, a cycle model of the array and pipes, and the check task
//----------------------------------------------------------------------
`timescale 1ns/100ps
`include "regFile_params.svh"

module regFileTb;

  logic                clock;
  logic                arstN;
  logic                scanMode;
  logic                wrEn;
  regFilePkg::rfAddrT  wrAddr;
  regFilePkg::rfDataT  wrData;
  logic                rdEn;
  regFilePkg::rfAddrT  rdAddr;
  regFilePkg::rfDataT  rdData;
  regFilePkg::rfObsT   obsOut;

  // model of the stored words and which of them the fill has reached
  regFilePkg::rfDataT  modelMem [0:`RF_DEPTH-1];
  logic                written [0:`RF_DEPTH-1];

  // requests sampled at the previous edge form the second stage of the model pipe
  logic                pScan, pWrEn, pRdEn;
  regFilePkg::rfAddrT  pWrAddr, pRdAddr;
  regFilePkg::rfDataT  pWrData;

  // expected read data and scratch values of the phases
  regFilePkg::rfDataT  expRd, oldWord, newWord, held;
  regFilePkg::rfAddrT  addr;
  logic                we, re;
  int                  obsEdges, done, guard, i, idleLen;
  string               testName;

  regFileTop uut (
    .clock    (clock),
    .arstN    (arstN),
    .scanMode (scanMode),
    .wrEn     (wrEn),
    .wrAddr   (wrAddr),
    .wrData   (wrData),
    .rdEn     (rdEn),
    .rdAddr   (rdAddr),
    .rdData   (rdData),
    .obsOut   (obsOut)
  );

  initial clock = 1'b0;
  always #20 clock = ~clock;

  //--------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------

  task automatic checkValue(string what, regFilePkg::rfDataT expected,
                            regFilePkg::rfDataT actual);
    if (actual !== expected)
    begin
      $display("FAILED %s %s expected %h actual %h", testName, what, expected, actual);
      $display("** FAIL **");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic abortOnTimeout(string what);
    $display("timeout in %s: %s", testName, what);
    $display("** FAIL **");
    $fatal(1, "stopping on a timeout");
  endtask

  function automatic regFilePkg::rfAddrT randAddr();
    logic [31:0] raw;
    raw = $urandom();
    return raw[`RF_ADDR_BITS-1:0];
  endfunction

  function automatic logic randBit();
    logic [31:0] raw;
    raw = $urandom();
    return raw[0];
  endfunction

  function automatic regFilePkg::rfDataT randWord();
    logic [95:0] raw;
    raw = {$urandom(), $urandom(), $urandom()};
    return raw[`RF_WIDTH-1:0];
  endfunction

  // parity of each run of three observed bits where the top run holds one bit
  function automatic regFilePkg::rfObsT groupParity(logic [2*`RF_ADDR_BITS+1:0] bus);
    regFilePkg::rfObsT                result;
    logic [2*`RF_ADDR_BITS+1:0]       shifted;
    int                               k;
    result = '0;
    for (k = 0; k < 2*`RF_ADDR_BITS+2; k++)
    begin
      shifted = bus >> k;
      if (shifted[0])
        result = result ^ (regFilePkg::rfObsT'(1) << (k / `RF_OBS_XOR_SIZE));
    end
    return result;
  endfunction

  task automatic driveInputs(logic sm, logic wen, regFilePkg::rfAddrT wa,
                             regFilePkg::rfDataT wd, logic ren, regFilePkg::rfAddrT ra);
    scanMode = sm;
    wrEn     = wen;
    wrAddr   = wa;
    wrData   = wd;
    rdEn     = ren;
    rdAddr   = ra;
  endtask

  // each model edge lets the read see the array before the pending
  // write lands, then the inputs held over the edge become the new pipe
  task automatic clockStep();
    regFilePkg::rfObsT expObs;
    @(posedge clock);
    #2;
    if (pRdEn)
    begin
      if (pScan)
        expRd = pWrEn ? pWrData : '0;
      else
        expRd = modelMem[pRdAddr];
    end
    if (pWrEn && !pScan)
      modelMem[pWrAddr] = pWrData;
    expObs  = groupParity({pRdEn, pRdAddr, pWrEn, pWrAddr});
    pScan   = scanMode;
    pWrEn   = wrEn;
    pWrAddr = wrAddr;
    pWrData = wrData;
    pRdEn   = rdEn;
    pRdAddr = rdAddr;
    checkValue("rdData", expRd, rdData);
    // observation flops carry no reset, so skip the first edges after it
    if (obsEdges >= 2)
      checkValue("obsOut", regFilePkg::rfDataT'(expObs), regFilePkg::rfDataT'(obsOut));
    else
      obsEdges++;
  endtask

  //--------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------

  initial
  begin
    void'($urandom(32'h6762));
    arstN    = 1'b0;
    driveInputs(1'b0, 1'b0, '0, '0, 1'b0, '0);
    {pScan, pWrEn, pRdEn} = 3'b000;
    pWrAddr  = '0;
    pRdAddr  = '0;
    pWrData  = '0;
    expRd    = '0;
    obsEdges = 0;
    testName = "reset";
    for (i = 0; i < `RF_DEPTH; i++)
      written[i] = 1'b0;

    guard = 0;
    while (guard < 16)
    begin
      @(posedge clock);
      guard++;
    end
    #2;
    arstN = 1'b1;
    checkValue("rdData", '0, rdData);

    // random addresses until every word holds a known value
    testName = "fill";
    done = 0;
    guard = 0;
    while (done < `RF_DEPTH)
    begin
      addr = randAddr();
      driveInputs(1'b0, 1'b1, addr, randWord(), 1'b0, randAddr());
      clockStep();
      if (!written[addr])
      begin
        written[addr] = 1'b1;
        done++;
      end
      guard++;
      if (guard > 4000)
        abortOnTimeout("fill did not reach every word");
    end

    testName = "random traffic";
    done = 0;
    guard = 0;
    while (done < 300)
    begin
      we = randBit();
      re = randBit();
      driveInputs(1'b0, we, randAddr(), randWord(), re, randAddr());
      clockStep();
      if (re)
        done++;
      guard++;
      if (guard > 2000)
        abortOnTimeout("too few reads issued");
    end

    // write and read of one word at one edge, then a read at the next edge
    testName = "same edge";
    done = 0;
    guard = 0;
    while (done < 8)
    begin
      addr = randAddr();
      newWord = randWord();
      driveInputs(1'b0, 1'b0, '0, '0, 1'b0, '0);
      clockStep();
      oldWord = modelMem[addr];
      driveInputs(1'b0, 1'b1, addr, newWord, 1'b1, addr);
      clockStep();
      driveInputs(1'b0, 1'b0, addr, '0, 1'b1, addr);
      clockStep();
      checkValue("old word", oldWord, rdData);
      driveInputs(1'b0, 1'b0, '0, '0, 1'b0, '0);
      clockStep();
      checkValue("new word", newWord, rdData);
      done++;
      guard += 4;
      if (guard > 100)
        abortOnTimeout("same edge pairs did not finish");
    end

    // one read, then a random stretch with rdEn low while writes go on
    testName = "idle hold";
    done = 0;
    guard = 0;
    while (done < 20)
    begin
      idleLen = int'($urandom_range(8, 1));
      driveInputs(1'b0, randBit(), randAddr(), randWord(), 1'b1, randAddr());
      clockStep();
      driveInputs(1'b0, randBit(), randAddr(), randWord(), 1'b0, randAddr());
      clockStep();
      held = expRd;
      for (i = 0; i < idleLen; i++)
      begin
        driveInputs(1'b0, randBit(), randAddr(), randWord(), 1'b0, randAddr());
        clockStep();
        checkValue("held rdData", held, rdData);
      end
      done++;
      guard += idleLen + 2;
      if (guard > 400)
        abortOnTimeout("idle stretches did not finish");
    end

    testName = "scan write-through";
    done = 0;
    guard = 0;
    while (done < 100)
    begin
      we = randBit();
      re = randBit();
      driveInputs(1'b1, we, randAddr(), randWord(), re, randAddr());
      clockStep();
      if (re)
        done++;
      guard++;
      if (guard > 800)
        abortOnTimeout("too few scan reads issued");
    end

    // back in normal mode every word must still hold its pre-scan value
    testName = "scan readback";
    done = 0;
    guard = 0;
    while (done < `RF_DEPTH)
    begin
      driveInputs(1'b0, 1'b0, randAddr(), randWord(), 1'b1, regFilePkg::rfAddrT'(done));
      clockStep();
      done++;
      guard++;
      if (guard > `RF_DEPTH + 10)
        abortOnTimeout("readback did not finish");
    end

    // drain the last read
    driveInputs(1'b0, 1'b0, '0, '0, 1'b0, '0);
    for (i = 0; i < 3; i++)
      clockStep();

    $display("** PASS **");
    $finish;
  end

endmodule

// File: verilog/regFilePkg.sv
//----------------------------------------------------------------------
// shared types of the register file: address, data word and
// the observation vector seen by the scan tool
//----------------------------------------------------------------------
`include "regFile_params.svh"

package regFilePkg;

  // word address into the storage array
  typedef logic [`RF_ADDR_BITS-1:0] rfAddrT;

  // one stored word
  typedef logic [`RF_WIDTH-1:0] rfDataT;

  // observed bus is both addresses plus the write and read enables
  localparam int obsPinCount = 2 * `RF_ADDR_BITS + 2;

  // one flop per group, and a short last group still gets its own flop
  localparam int obsFlopCount = (obsPinCount + `RF_OBS_XOR_SIZE - 1) / `RF_OBS_XOR_SIZE;

  // registered group parity of the observed bus
  typedef logic [obsFlopCount-1:0] rfObsT;

endpackage

// File: verilog/regFileTop.sv
//----------------------------------------------------------------------
// top level of the 128 x 66 1R1W register file with scan
// write-through and observation flops
//----------------------------------------------------------------------
`timescale 1ns/100ps
`include "regFile_params.svh"

module regFileTop
(
  input  logic                clock,
  input  logic                arstN,
  input  logic                scanMode,
  input  logic                wrEn,
  input  regFilePkg::rfAddrT  wrAddr,
  input  regFilePkg::rfDataT  wrData,
  input  logic                rdEn,
  input  regFilePkg::rfAddrT  rdAddr,
  output regFilePkg::rfDataT  rdData,
  output regFilePkg::rfObsT   obsOut
);

  //--------------------------------------------------------------------
  // internal wires
  //--------------------------------------------------------------------

  // gated write request into the array
  logic                arrWrEn;
  regFilePkg::rfAddrT  arrWrAddr;
  regFilePkg::rfDataT  arrWrData;

  // ungated write request for the write-through path
  logic                stageWrEn;
  regFilePkg::rfDataT  stageWrData;

  // read request into the array and the word coming back
  regFilePkg::rfAddrT  arrRdAddr;
  regFilePkg::rfDataT  arrRdData;
  logic                stageRdEn;

  //--------------------------------------------------------------------
  // instances
  //--------------------------------------------------------------------

  rfWriteStage uWrite (
    .clock       (clock),
    .arstN       (arstN),
    .scanMode    (scanMode),
    .wrEn        (wrEn),
    .wrAddr      (wrAddr),
    .wrData      (wrData),
    .arrWrEn     (arrWrEn),
    .arrWrAddr   (arrWrAddr),
    .arrWrData   (arrWrData),
    .stageWrEn   (stageWrEn),
    .stageWrData (stageWrData)
  );

  rfStorageArray uArray (
    .clock     (clock),
    .arrWrEn   (arrWrEn),
    .arrWrAddr (arrWrAddr),
    .arrWrData (arrWrData),
    .arrRdAddr (arrRdAddr),
    .arrRdData (arrRdData)
  );

  rfReadStage uRead (
    .clock       (clock),
    .arstN       (arstN),
    .scanMode    (scanMode),
    .rdEn        (rdEn),
    .rdAddr      (rdAddr),
    .arrRdData   (arrRdData),
    .stageWrEn   (stageWrEn),
    .stageWrData (stageWrData),
    .arrRdAddr   (arrRdAddr),
    .stageRdEn   (stageRdEn),
    .rdData      (rdData)
  );

  // observed bus from bit 0 up is write address, write enable,
  // read address, read enable
  rfObserveFlops #(
    .pinCount (regFilePkg::obsPinCount),
    .xorSize  (`RF_OBS_XOR_SIZE)
  ) uObserve (
    .clock  (clock),
    .obsIn  ({stageRdEn, arrRdAddr, stageWrEn, arrWrAddr}),
    .obsOut (obsOut)
  );

endmodule

// File: verilog/regFile_params.svh
//----------------------------------------------------------------------
// size parameters of the 1R1W register file and group size
// of its scan observation flops
//----------------------------------------------------------------------
`ifndef REGFILE_PARAMS_SVH
`define REGFILE_PARAMS_SVH

// number of words held in the storage array
`define RF_DEPTH 128

// bits per stored word
`define RF_WIDTH 66

// address bits needed to reach every word
`define RF_ADDR_BITS 7

// observed signals folded into one observation flop
`define RF_OBS_XOR_SIZE 3

`endif

// File: verilog/rfObserveFlops.sv
//----------------------------------------------------------------------
// scan observation flops that register the group parity of the
// address and control signals reaching the storage array
//----------------------------------------------------------------------
`timescale 1ns/100ps
`include "regFile_params.svh"

module rfObserveFlops
#(
  parameter int pinCount  = regFilePkg::obsPinCount,
  parameter int xorSize   = `RF_OBS_XOR_SIZE,
  parameter int flopCount = (pinCount / xorSize) + int'((pinCount % xorSize) > 0)
)
(
  input  logic                 clock,
  input  logic [pinCount-1:0]  obsIn,
  output regFilePkg::rfObsT    obsOut
);

  // parity of each group before it is registered
  logic [flopCount-1:0] obsWires;

  // registered parity seen by the scan tool
  logic [flopCount-1:0] obsFlops;

  // each group of xorSize bits folds into one flop and the top group
  // takes whatever is left
  for (genvar g = 0; g < flopCount; g++)
  begin : gGroup
    if (g < flopCount - 1)
    begin : gFull
      assign obsWires[g] = ^obsIn[g*xorSize +: xorSize];
    end
    else
    begin : gLast
      assign obsWires[g] = ^obsIn[pinCount-1 : g*xorSize];
    end
  end

  // these flops only capture the parity for the scan tool to observe
  always_ff @(posedge clock)
  begin
    obsFlops <= obsWires;
  end

  assign obsOut = obsFlops;

endmodule

// File: verilog/rfReadStage.sv
//----------------------------------------------------------------------
// read side of the register file that captures the read request, picks
// the array word or the write-through word and holds the read data
//----------------------------------------------------------------------
`timescale 1ns/100ps

module rfReadStage
(
  input  logic                clock,
  input  logic                arstN,
  input  logic                scanMode,
  input  logic                rdEn,
  input  regFilePkg::rfAddrT  rdAddr,
  input  regFilePkg::rfDataT  arrRdData,
  input  logic                stageWrEn,
  input  regFilePkg::rfDataT  stageWrData,
  output regFilePkg::rfAddrT  arrRdAddr,
  output logic                stageRdEn,
  output regFilePkg::rfDataT  rdData
);

  // mode captured together with the read request
  logic scanQ;

  // word the pending read will return
  regFilePkg::rfDataT nextRdData;

  // request capture at the edge the read is sampled
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      stageRdEn <= 1'b0;
      arrRdAddr <= '0;
      scanQ     <= 1'b0;
    end
    else
    begin
      stageRdEn <= rdEn;
      arrRdAddr <= rdAddr;
      scanQ     <= scanMode;
    end
  end

  // in write-through mode the read bypasses the array and returns the
  // write sampled at the same edge, or zero when there was no write
  assign nextRdData = scanQ ? (stageWrEn ? stageWrData : '0) : arrRdData;

  // read data loads one edge after the request and otherwise holds
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      rdData <= '0;
    end
    else if (stageRdEn)
    begin
      rdData <= nextRdData;
    end
  end

  // an idle read at the port leaves the output untouched two edges on
  assert property (@(posedge clock) disable iff (!arstN)
    !rdEn |=> ##1 $stable(rdData));

endmodule

// File: verilog/rfStorageArray.sv
//----------------------------------------------------------------------
// 128 x 66 storage array with a synchronous write port and a
// combinational read port
//----------------------------------------------------------------------
`timescale 1ns/100ps
`include "regFile_params.svh"

module rfStorageArray
(
  input  logic                clock,
  input  logic                arrWrEn,
  input  regFilePkg::rfAddrT  arrWrAddr,
  input  regFilePkg::rfDataT  arrWrData,
  input  regFilePkg::rfAddrT  arrRdAddr,
  output regFilePkg::rfDataT  arrRdData
);

  // the word storage itself
  regFilePkg::rfDataT memWords [0:`RF_DEPTH-1];

  //--------------------------------------------------------------------
  // write port
  //--------------------------------------------------------------------

  // the request captured by the write stage lands here one edge later
  always_ff @(posedge clock)
  begin
    if (arrWrEn)
    begin
      memWords[arrWrAddr] <= arrWrData;
    end
  end

  //--------------------------------------------------------------------
  // read port
  //--------------------------------------------------------------------

  // the read is combinational off the captured read address, so a write
  // landing at the same edge as the read data load is not seen yet
  assign arrRdData = memWords[arrRdAddr];

endmodule

// File: verilog/rfWriteStage.sv
//----------------------------------------------------------------------
// write side of the register file that captures the write request and
// decides whether the storage array takes it
//----------------------------------------------------------------------
`timescale 1ns/100ps

module rfWriteStage
(
  input  logic                clock,
  input  logic                arstN,
  input  logic                scanMode,
  input  logic                wrEn,
  input  regFilePkg::rfAddrT  wrAddr,
  input  regFilePkg::rfDataT  wrData,
  output logic                arrWrEn,
  output regFilePkg::rfAddrT  arrWrAddr,
  output regFilePkg::rfDataT  arrWrData,
  output logic                stageWrEn,
  output regFilePkg::rfDataT  stageWrData
);

  // the captured write word feeds both the array and the write-through path
  regFilePkg::rfDataT wrDataQ;

  // the control capture drops the array strobe while scan write-through is on
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      arrWrEn   <= 1'b0;
      arrWrAddr <= '0;
      stageWrEn <= 1'b0;
    end
    else
    begin
      arrWrEn   <= wrEn && !scanMode;
      arrWrAddr <= wrAddr;
      stageWrEn <= wrEn;
    end
  end

  // the write word only moves when a write is requested
  always_ff @(posedge clock)
  begin
    if (wrEn)
    begin
      wrDataQ <= wrData;
    end
  end

  assign arrWrData   = wrDataQ;
  assign stageWrData = wrDataQ;

  // a write request must carry a known address so that it names one word
  assert property (@(posedge clock) disable iff (!arstN)
    wrEn |-> !$isunknown(wrAddr));

endmodule
